// File: hdl/aesPkg.sv
`default_nettype none

package aesPkg;

	// Widths with a meaning
	typedef logic [127:0] block_t;  // Byte 0 in bits 127:120
	typedef logic [31:0] word_t;    // One column or key word
	typedef logic [7:0] byte_t;     // GF(2^8) element
	typedef logic [3:0] round_t;    // Round index 0 to 10

	localparam round_t NumRounds = 4'd10;  // AES-128

	// Operation on the state register this cycle
	typedef enum logic [2:0] {
		opHold,     // Keep state
		opLoad,     // Take ciphertext
		opInitial,  // XOR with round key
		opRound,    // Full inverse round
		opFinal     // Last round, no InvMixColumns
	} stateOp_t;

	// Controller to key store and state register
	typedef struct packed {
		stateOp_t stateOp;
		round_t round;   // Key write index in expansion, read index in decryption
		logic keyLoad;   // Cipher key into slot 0
		logic keyStep;   // Derive key round from key round-1
	} roundCtrl_t;

	typedef struct packed {
		block_t cipherKey;
		block_t cipherText;
	} decryptRequest_t;

	// Multiply by x, reduce by the AES polynomial
	function automatic byte_t xtime(input byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	// Shift and add product
	function automatic byte_t gfMul(input byte_t a, input byte_t b);
		byte_t acc;
		byte_t p;
		acc = '0;
		p = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc ^= p;  // Add this power of a
			p = xtime(p);
		end
		return acc;
	endfunction

	// a^254 is the inverse, and 0 stays 0
	function automatic byte_t gfInverse(input byte_t a);
		byte_t sq;
		byte_t acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gfMul(sq, sq);    // a^(2^i)
			acc = gfMul(acc, sq);  // Exponents 2 through 128 summed
		end
		return acc;
	endfunction

	// Forward S-box, inverse followed by the affine map
	function automatic byte_t sbox(input byte_t a);
		byte_t b;
		b = gfInverse(a);
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]}
			^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
	endfunction

	// Inverse affine map first, then the field inverse
	function automatic byte_t invSbox(input byte_t a);
		byte_t b;
		b = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;  // Rotates 1, 3, 6
		return gfInverse(b);
	endfunction

	// Round constant, x^(r-1) for rounds 1 to 10
	function automatic byte_t rcon(input round_t r);
		byte_t c;
		c = 8'h01;
		for (int i = 2; i <= int'(NumRounds); i++) begin
			if (i <= int'(r))
				c = xtime(c);
		end
		return c;
	endfunction

endpackage

`default_nettype wire

// File: hdl/invMixColumns.sv
`default_nettype none

// Inverse MixColumns on all four columns at once
module invMixColumns (
	input aesPkg::block_t dataIn,
	output aesPkg::block_t dataOut
);

	// Top row of the inverse matrix, later rows rotate right
	localparam aesPkg::byte_t Coef [0:3] = '{8'h0e, 8'h0b, 8'h0d, 8'h09};

	always_comb begin
		aesPkg::byte_t acc;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				acc = '0;
				// Row r of the matrix times column c
				for (int k = 0; k < 4; k++) begin
					acc ^= aesPkg::gfMul(Coef[(k - r + 4) % 4],
						dataIn[127 - 8 * (4 * c + k) -: 8]);
				end
				dataOut[127 - 8 * (4 * c + r) -: 8] = acc;  // Byte r of column c
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/keyExpansion.sv
`default_nettype none

// Round key store, filled one key per cycle
module keyExpansion (
	input logic Clk,
	input logic Reset,
	input aesPkg::roundCtrl_t ctrl,
	input aesPkg::block_t cipherKey,
	output aesPkg::block_t roundKey
);

	aesPkg::block_t keyStore [0:aesPkg::NumRounds];  // Keys 0 to 10
	aesPkg::round_t prevIdx;
	aesPkg::block_t prevKey;
	aesPkg::block_t nextKey;
	aesPkg::word_t rotSub;  // SubWord(RotWord(w3)) with rcon
	aesPkg::word_t word0;
	aesPkg::word_t word1;
	aesPkg::word_t word2;
	aesPkg::word_t word3;

	assign prevIdx = ctrl.round - 4'd1;  // Only meaningful for rounds 1 to 10
	assign prevKey = keyStore[prevIdx];

	// Last word rotated left one byte, each byte through the S-box
	assign rotSub = {
		aesPkg::sbox(prevKey[23:16]),
		aesPkg::sbox(prevKey[15:8]),
		aesPkg::sbox(prevKey[7:0]),
		aesPkg::sbox(prevKey[31:24])
	} ^ {aesPkg::rcon(ctrl.round), 24'h0};  // rcon only on the top byte

	// Chained XOR across the four words
	assign word0 = prevKey[127:96] ^ rotSub;
	assign word1 = prevKey[95:64] ^ word0;
	assign word2 = prevKey[63:32] ^ word1;
	assign word3 = prevKey[31:0] ^ word2;
	assign nextKey = {word0, word1, word2, word3};

	always_ff @(posedge Clk or negedge Reset) begin
		if (!Reset) begin
			for (int i = 0; i <= int'(aesPkg::NumRounds); i++)
				keyStore[i] <= '0;
		end else if (ctrl.keyLoad) begin
			keyStore[0] <= cipherKey;  // Key 0 is the cipher key itself
		end else if (ctrl.keyStep) begin
			keyStore[ctrl.round] <= nextKey;
		end
	end

	// Read port follows the round index with no delay
	assign roundKey = keyStore[ctrl.round];

endmodule

`default_nettype wire

// File: hdl/invCipherState.sv
`default_nettype none

// State register and one inverse round per cycle
module invCipherState (
	input logic Clk,
	input logic Reset,
	input aesPkg::roundCtrl_t ctrl,
	input aesPkg::block_t cipherText,
	input aesPkg::block_t roundKey,
	output aesPkg::block_t state
);

	aesPkg::block_t subShifted;  // InvShiftRows then InvSubBytes
	aesPkg::block_t keyed;       // After AddRoundKey
	aesPkg::block_t mixed;       // After InvMixColumns

	// Byte i sits at row i%4, column i/4
	always_comb begin
		int src;
		for (int i = 0; i < 16; i++) begin
			src = i % 4 + 4 * ((i / 4 - i % 4 + 4) % 4);  // Row r rotates right by r
			subShifted[127 - 8 * i -: 8] = aesPkg::invSbox(state[127 - 8 * src -: 8]);
		end
	end

	assign keyed = subShifted ^ roundKey;

	invMixColumns mixCols (
		.dataIn(keyed),
		.dataOut(mixed)
	);

	always_ff @(posedge Clk or negedge Reset) begin
		if (!Reset) begin
			state <= '0;
		end else begin
			case (ctrl.stateOp)
				aesPkg::opLoad: state <= cipherText;
				aesPkg::opInitial: state <= state ^ roundKey;  // Key 10 only
				aesPkg::opRound: state <= mixed;
				aesPkg::opFinal: state <= keyed;  // Skips the mix
				default: state <= state;  // opHold, plaintext stays put
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/aesControl.sv
`default_nettype none

// Sequencer for key expansion and the inverse rounds
module aesControl (
	input logic Clk,
	input logic Reset,
	input logic Start,
	output aesPkg::roundCtrl_t ctrl,
	output logic Busy,
	output logic Done
);

	typedef enum logic [2:0] {
		Idle,
		Expand,   // Keys 1 to 10
		Initial,  // AddRoundKey with key 10
		Rounds,   // Rounds 9 down to 1
		Final     // Round 0, no mix
	} ctrlState_t;

	ctrlState_t ctrlState;
	ctrlState_t nextState;
	aesPkg::round_t roundCnt;  // Up in Expand, down in Rounds
	aesPkg::round_t nextRound;

	always_comb begin
		nextState = ctrlState;
		nextRound = roundCnt;
		case (ctrlState)
			Idle: begin
				if (Start) begin  // Only seen here, so a busy Start is dropped
					nextState = Expand;
					nextRound = 4'd1;
				end
			end
			Expand: begin
				if (roundCnt == aesPkg::NumRounds)
					nextState = Initial;  // Counter stays at 10
				else
					nextRound = roundCnt + 4'd1;
			end
			Initial: begin
				nextState = Rounds;
				nextRound = aesPkg::NumRounds - 4'd1;
			end
			Rounds: begin
				nextRound = roundCnt - 4'd1;
				if (roundCnt == 4'd1)
					nextState = Final;  // Leaves the counter at 0
			end
			Final: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge Clk or negedge Reset) begin
		if (!Reset) begin
			ctrlState <= Idle;
			roundCnt <= '0;
			Done <= 1'b0;
		end else begin
			ctrlState <= nextState;
			roundCnt <= nextRound;
			Done <= (ctrlState == Final);  // One cycle, state is Idle next
		end
	end

	// Load happens on the same edge that accepts Start
	always_comb begin
		ctrl.round = roundCnt;
		ctrl.keyLoad = (ctrlState == Idle) && Start;
		ctrl.keyStep = (ctrlState == Expand);
		case (ctrlState)
			Idle: ctrl.stateOp = Start ? aesPkg::opLoad : aesPkg::opHold;
			Initial: ctrl.stateOp = aesPkg::opInitial;
			Rounds: ctrl.stateOp = aesPkg::opRound;
			Final: ctrl.stateOp = aesPkg::opFinal;
			default: ctrl.stateOp = aesPkg::opHold;  // State untouched during expansion
		endcase
	end

	assign Busy = (ctrlState != Idle);

endmodule

`default_nettype wire

// File: hdl/aesDecrypt.sv
`default_nettype none

// AES-128 decryption core, 21 edges from Start to Done
module aesDecrypt (
	input logic Clk,
	input logic Reset,
	input logic Start,
	input aesPkg::decryptRequest_t Request,
	output aesPkg::block_t Plaintext,
	output logic Busy,
	output logic Done
);

	aesPkg::roundCtrl_t ctrl;      // Shared by key store and state register
	aesPkg::block_t roundKey;

	// Sequencer
	aesControl control (
		.Clk(Clk),
		.Reset(Reset),
		.Start(Start),
		.ctrl(ctrl),
		.Busy(Busy),
		.Done(Done)
	);

	// Key schedule, sampled with Start
	keyExpansion keys (
		.Clk(Clk),
		.Reset(Reset),
		.ctrl(ctrl),
		.cipherKey(Request.cipherKey),
		.roundKey(roundKey)
	);

	// Datapath, its register is the plaintext output
	invCipherState cipherState (
		.Clk(Clk),
		.Reset(Reset),
		.ctrl(ctrl),
		.cipherText(Request.cipherText),
		.roundKey(roundKey),
		.state(Plaintext)
	);

endmodule

`default_nettype wire

// File: sim/aesDecrypt_assert.sv
`default_nettype none

// Handshake properties of the decryption core
module aesDecryptAssert (
	input logic Clk,
	input logic Reset,
	input logic Start,
	input logic Busy,
	input logic Done
);
	timeunit 1ns;
	timeprecision 100ps;

	// Done is a strobe
	doneSingle: assert property (@(posedge Clk) disable iff (!Reset) Done |=> !Done)
		else $error("Done stayed high for two cycles");

	// Accepted Start, then Busy through edge t+21, then Done with Busy low
	busyWindow: assert property (@(posedge Clk) disable iff (!Reset)
		(Start && !Busy) |=> Busy [*21] ##1 (!Busy && Done))
		else $error("Busy window or Done timing wrong after an accepted Start");

	resetQuiet: assert property (@(posedge Clk) !Reset |-> (!Busy && !Done))
		else $error("Busy or Done active during reset");

endmodule

bind aesDecrypt aesDecryptAssert handshakeCheck (
	.Clk(Clk),
	.Reset(Reset),
	.Start(Start),
	.Busy(Busy),
	.Done(Done)
);

`default_nettype wire

// File: sim/aesDecryptTb.sv
`default_nettype none

// Directed tests for the AES-128 decryption core
module aesDecryptTb;
	timeunit 1ns;
	timeprecision 100ps;

	logic Clk = 1'b0;
	logic Reset;
	logic Start;
	aesPkg::decryptRequest_t Request;
	aesPkg::block_t Plaintext;
	logic Busy;
	logic Done;
	int errorCount = 0;
	int timeoutCount = 0;

	always #10 Clk = ~Clk;  // 20 ns period

	aesDecrypt uut (
		.Clk(Clk),
		.Reset(Reset),
		.Start(Start),
		.Request(Request),
		.Plaintext(Plaintext),
		.Busy(Busy),
		.Done(Done)
	);

	task automatic checkValue(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	// Forward MixColumns on one column
	function automatic aesPkg::word_t mixColumn(input aesPkg::word_t col);
		aesPkg::byte_t a [0:3];
		for (int k = 0; k < 4; k++)
			a[k] = col[31 - 8 * k -: 8];
		return {aesPkg::xtime(a[0]) ^ aesPkg::xtime(a[1]) ^ a[1] ^ a[2] ^ a[3],
			a[0] ^ aesPkg::xtime(a[1]) ^ aesPkg::xtime(a[2]) ^ a[2] ^ a[3],
			a[0] ^ a[1] ^ aesPkg::xtime(a[2]) ^ aesPkg::xtime(a[3]) ^ a[3],
			aesPkg::xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ aesPkg::xtime(a[3])};
	endfunction

	// Reference encryption, FIPS-197 forward cipher
	function automatic aesPkg::block_t encryptBlock(input aesPkg::block_t key,
		input aesPkg::block_t plain);
		aesPkg::word_t w [0:43];  // Full key schedule
		aesPkg::word_t temp;
		aesPkg::block_t st;
		aesPkg::block_t shifted;
		int src;
		for (int i = 0; i < 4; i++)
			w[i] = key[127 - 32 * i -: 32];
		for (int i = 4; i < 44; i++) begin
			temp = w[i - 1];
			if (i % 4 == 0)  // RotWord, SubWord, rcon
				temp = {aesPkg::sbox(temp[23:16]), aesPkg::sbox(temp[15:8]),
					aesPkg::sbox(temp[7:0]), aesPkg::sbox(temp[31:24])}
					^ {aesPkg::rcon(aesPkg::round_t'(i / 4)), 24'h0};
			w[i] = w[i - 4] ^ temp;
		end
		st = plain ^ {w[0], w[1], w[2], w[3]};
		for (int r = 1; r <= 10; r++) begin
			for (int i = 0; i < 16; i++) begin
				src = i % 4 + 4 * ((i / 4 + i % 4) % 4);  // Row rotates left
				shifted[127 - 8 * i -: 8] = aesPkg::sbox(st[127 - 8 * src -: 8]);
			end
			if (r < 10) begin  // No mix in the last round
				for (int c = 0; c < 4; c++)
					shifted[127 - 32 * c -: 32] = mixColumn(shifted[127 - 32 * c -: 32]);
			end
			st = shifted ^ {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
		end
		return st;
	endfunction

	// One-cycle Start, returns on the edge that samples it
	task automatic startRun(input aesPkg::block_t key, input aesPkg::block_t ct);
		@(posedge Clk);
		Start <= 1'b1;
		Request.cipherKey <= key;
		Request.cipherText <= ct;
		@(posedge Clk);
		Start <= 1'b0;
	endtask

	// Counts falling edges until Done, Busy low before Done is tallied
	task automatic waitForDone(output int cycles, output int busyLow);
		logic seen;
		seen = 1'b0;
		cycles = 0;
		busyLow = 0;
		while (!seen && cycles < 40) begin
			@(negedge Clk);
			cycles++;
			if (Done)
				seen = 1'b1;
			else if (!Busy)
				busyLow++;
		end
		if (!seen) begin
			timeoutCount++;
			$display("Timeout at %0t: Done did not arrive within 40 cycles", $time);
		end
	endtask

	task automatic runVector(input aesPkg::block_t key, input aesPkg::block_t ct,
		input aesPkg::block_t expected);
		int cycles;
		int busyLow;
		startRun(key, ct);
		waitForDone(cycles, busyLow);
		checkValue("Plaintext", Plaintext, expected);
	endtask

	task automatic standardVectors();
		// Model checked against the published ciphertexts first
		checkValue("model ciphertext", encryptBlock(128'h000102030405060708090a0b0c0d0e0f,
			128'h00112233445566778899aabbccddeeff), 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		checkValue("model ciphertext", encryptBlock(128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3243f6a8885a308d313198a2e0370734), 128'h3925841d02dc09fbdc118597196a0b32);
		runVector(128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
			128'h00112233445566778899aabbccddeeff);
		runVector(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3925841d02dc09fbdc118597196a0b32,
			128'h3243f6a8885a308d313198a2e0370734);
	endtask

	task automatic randomRoundTrip();
		aesPkg::block_t key;
		aesPkg::block_t plain;
		for (int i = 0; i < 20; i++) begin
			key = {$urandom, $urandom, $urandom, $urandom};
			plain = {$urandom, $urandom, $urandom, $urandom};
			runVector(key, encryptBlock(key, plain), plain);
			if (i % 3 != 0) begin  // Otherwise the next Start follows Done directly
				repeat ($urandom_range(4, 1)) @(negedge Clk);
				checkValue("held Plaintext", Plaintext, plain);
			end
		end
	endtask

	task automatic measureLatency();
		int cycles;
		int busyLow;
		startRun(128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		waitForDone(cycles, busyLow);
		checkValue("Done latency", 128'(cycles - 1), 128'd21);  // Edges after the Start edge
		checkValue("Busy low before Done", 128'(busyLow), 128'd0);
		checkValue("Busy with Done", 128'(Busy), 128'd0);
	endtask

	task automatic ignoredStart();
		int cycles;
		int busyLow;
		int extraDone;
		extraDone = 0;
		startRun(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3925841d02dc09fbdc118597196a0b32);
		repeat (5) @(posedge Clk);
		Start <= 1'b1;  // Second request while busy
		Request.cipherKey <= 128'h000102030405060708090a0b0c0d0e0f;
		Request.cipherText <= 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		@(posedge Clk);
		Start <= 1'b0;
		waitForDone(cycles, busyLow);
		checkValue("Plaintext", Plaintext, 128'h3243f6a8885a308d313198a2e0370734);
		repeat (30) begin
			@(negedge Clk);
			if (Done)
				extraDone++;
		end
		checkValue("extra Done count", 128'(extraDone), 128'd0);
	endtask

	task automatic resetMidRun();
		startRun(128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		repeat (7) @(posedge Clk);
		Reset <= 1'b0;
		@(negedge Clk);
		checkValue("Busy in reset", 128'(Busy), 128'd0);
		checkValue("Done in reset", 128'(Done), 128'd0);
		repeat (3) @(posedge Clk);
		Reset <= 1'b1;
		runVector(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3925841d02dc09fbdc118597196a0b32,
			128'h3243f6a8885a308d313198a2e0370734);
	endtask

	initial begin
		void'($urandom(32'h4685));
		Reset = 1'b0;
		Start = 1'b0;
		Request = '0;
		repeat (8) @(posedge Clk);
		Reset <= 1'b1;
		standardVectors();
		randomRoundTrip();
		measureLatency();
		ignoredStart();
		resetMidRun();
		repeat (2) @(negedge Clk);
		$display("Finished with %0d errors and %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: aesDecrypt.f
hdl/aesPkg.sv
hdl/invMixColumns.sv
hdl/keyExpansion.sv
hdl/invCipherState.sv
hdl/aesControl.sv
hdl/aesDecrypt.sv
sim/aesDecrypt_assert.sv
sim/aesDecryptTb.sv

// File: Makefile
BIN := obj_dir/VaesDecryptTb
SOURCES := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): aesDecrypt.f $(SOURCES)
	verilator --binary --assert --timing --top-module aesDecryptTb -f aesDecrypt.f -Mdir obj_dir

# Fails on a simulator error or when the log holds the fail message
run: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	test $$status -eq 0 && ! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log
